/* hdl/dm_pkg.sv */
/*
 * shared constants and structs for the debug-module register slave
 * register addresses are word addresses as seen on the bus
 * only the access-memory layout of the command word is described here
 */
package dm_pkg;

    // bus and register widths
    localparam int DM_ADDR_W = 32;
    localparam int DM_DATA_W = 64;
    // hart word, used for pc and fetched instructions
    localparam int DM_XLEN   = 32;

    // debug register map
    localparam logic [DM_ADDR_W-1:0] DM_ADDR_DATA0     = 32'h0000_0004;
    localparam logic [DM_ADDR_W-1:0] DM_ADDR_DATA1     = 32'h0000_0005;
    localparam logic [DM_ADDR_W-1:0] DM_ADDR_DMCONTROL = 32'h0000_0010;
    localparam logic [DM_ADDR_W-1:0] DM_ADDR_COMMAND   = 32'h0000_0017;

    // abstract command type for memory access
    localparam logic [7:0] DM_CMDTYPE_ACCESS_MEM = 8'h02;

    // one write into the register file, en is high for a single cycle
    typedef struct packed {
        logic                 en;
        logic [DM_ADDR_W-1:0] addr;
        logic [DM_DATA_W-1:0] data;
    } dm_reg_wr_t;

    // access-memory view of the command word, msb first
    typedef struct packed {
        logic [7:0]  cmdtype;
        logic        aamvirtual;
        logic [2:0]  aamsize;
        logic        aampostincrement;
        logic [1:0]  reserved_hi;
        // set means memory write, clear means memory read
        logic        aamwrite;
        logic [1:0]  target_specific;
        logic [13:0] reserved_lo;
    } dm_mem_cmd_t;

    // memory read result returned to data0
    typedef struct packed {
        logic               valid;
        logic [DM_XLEN-1:0] data;
    } dm_mem_result_t;

endpackage

/* hdl/wb_dm_bus_slave.sv */
/*
 * classic strobe bus slave, no wait states and no back-pressure
 * master must hold addr, we and data stable until it sees ack
 * one register write per bus cycle however long the request is held
 */
`timescale 1ns/1ns

module wb_dm_bus_slave (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          cyc_i,
    input  logic                          stb_i,
    input  logic                          we_i,
    input  logic [dm_pkg::DM_ADDR_W-1:0]  addr_i,
    input  logic [dm_pkg::DM_DATA_W-1:0]  data_i,
    input  logic [dm_pkg::DM_DATA_W-1:0]  rd_data_i,
    output logic                          ack_o,
    output logic [dm_pkg::DM_DATA_W-1:0]  data_o,
    output dm_pkg::dm_reg_wr_t            reg_wr_o
);
    import dm_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE
    } state_t;

    state_t               state_q;
    logic                 ack_q;
    logic [DM_DATA_W-1:0] data_q;
    // set once the write of the current bus cycle has been issued
    logic                 done_q;
    logic                 req;

    assign req = cyc_i & stb_i;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q <= ST_IDLE;
            ack_q   <= 1'b0;
            data_q  <= '0;
            done_q  <= 1'b0;
        end
        else
        begin
            case (state_q)
                ST_IDLE:
                begin
                    ack_q  <= 1'b0;
                    data_q <= '0;
                    done_q <= 1'b0;
                    if (req)
                    begin
                        state_q <= we_i ? ST_WRITE : ST_READ;
                    end
                end
                ST_READ, ST_WRITE:
                begin
                    if (req)
                    begin
                        // ack stays up as long as the master holds the request
                        ack_q  <= 1'b1;
                        data_q <= (state_q == ST_READ) ? rd_data_i : '0;
                        done_q <= (state_q == ST_WRITE);
                    end
                    else
                    begin
                        ack_q   <= 1'b0;
                        data_q  <= '0;
                        done_q  <= 1'b0;
                        state_q <= ST_IDLE;
                    end
                end
                default:
                begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // strobe only in the first write cycle, register file takes it on the next edge
    assign reg_wr_o.en   = (state_q == ST_WRITE) && req && !done_q;
    assign reg_wr_o.addr = addr_i;
    assign reg_wr_o.data = data_i;

    assign ack_o  = ack_q;
    assign data_o = data_q;

endmodule

/* hdl/dm_register_file.sv */
/*
 * data0, data1, dmcontrol and command of the debug module
 * data0 keeps only the low hart word of a bus write, upper half reads zero
 * unmapped addresses read as zero and drop writes
 */
`timescale 1ns/1ns

module dm_register_file (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  dm_pkg::dm_reg_wr_t            reg_wr_i,
    input  logic [dm_pkg::DM_ADDR_W-1:0]  addr_i,
    input  dm_pkg::dm_mem_result_t        mem_result_i,
    output logic [dm_pkg::DM_DATA_W-1:0]  rd_data_o,
    output logic [dm_pkg::DM_DATA_W-1:0]  data1_o,
    output logic                          cmd_start_o,
    output logic [31:0]                   cmd_word_o
);
    import dm_pkg::*;

    localparam int PAD_W = DM_DATA_W - DM_XLEN;

    logic [DM_DATA_W-1:0] data0_q;
    logic [DM_DATA_W-1:0] data1_q;
    logic [DM_DATA_W-1:0] dmcontrol_q;
    logic [DM_DATA_W-1:0] command_q;
    logic                 cmd_start_q;

    // write decode
    logic wr_data0;
    logic wr_data1;
    logic wr_dmcontrol;
    logic wr_command;

    assign wr_data0     = reg_wr_i.en && (reg_wr_i.addr == DM_ADDR_DATA0);
    assign wr_data1     = reg_wr_i.en && (reg_wr_i.addr == DM_ADDR_DATA1);
    assign wr_dmcontrol = reg_wr_i.en && (reg_wr_i.addr == DM_ADDR_DMCONTROL);
    assign wr_command   = reg_wr_i.en && (reg_wr_i.addr == DM_ADDR_COMMAND);

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            data0_q     <= '0;
            data1_q     <= '0;
            dmcontrol_q <= '0;
            command_q   <= '0;
            cmd_start_q <= 1'b0;
        end
        else
        begin
            // data0 has two write ports, bus write first
            if (wr_data0)
            begin
                data0_q <= {{PAD_W{1'b0}}, reg_wr_i.data[DM_XLEN-1:0]};
            end
            // a memory result in the same cycle takes precedence
            if (mem_result_i.valid)
            begin
                data0_q <= {{PAD_W{1'b0}}, mem_result_i.data};
            end
            if (wr_data1)
            begin
                data1_q <= reg_wr_i.data;
            end
            if (wr_dmcontrol)
            begin
                dmcontrol_q <= reg_wr_i.data;
            end
            if (wr_command)
            begin
                command_q <= reg_wr_i.data;
            end
            // start pulse lines up with the stored command word
            cmd_start_q <= wr_command;
        end
    end

    // combinational read mux
    always_comb
    begin
        case (addr_i)
            DM_ADDR_DATA0:     rd_data_o = data0_q;
            DM_ADDR_DATA1:     rd_data_o = data1_q;
            DM_ADDR_DMCONTROL: rd_data_o = dmcontrol_q;
            DM_ADDR_COMMAND:   rd_data_o = command_q;
            default:           rd_data_o = '0;
        endcase
    end

    assign data1_o     = data1_q;
    assign cmd_start_o = cmd_start_q;
    assign cmd_word_o  = command_q[31:0];

endmodule

/* hdl/dm_abstract_cmd.sv */
/*
 * access-memory abstract command, memory reads only
 * address comes from data1[31:0], memory answers combinationally on instr_i
 * any other command type, and memory writes, are ignored
 */
`timescale 1ns/1ns

module dm_abstract_cmd (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          cmd_start_i,
    input  logic [31:0]                   cmd_word_i,
    input  logic [dm_pkg::DM_DATA_W-1:0]  data1_i,
    input  logic [dm_pkg::DM_XLEN-1:0]    instr_i,
    output logic [dm_pkg::DM_XLEN-1:0]    pc_o,
    output dm_pkg::dm_mem_result_t        mem_result_o
);
    import dm_pkg::*;

    dm_mem_cmd_t        cmd;
    logic               is_mem_read;
    logic [DM_XLEN-1:0] pc_q;
    // high in the cycle where pc is valid and instr_i answers for it
    logic               pending_q;

    assign cmd = cmd_word_i;

    // access-memory with aamwrite clear
    assign is_mem_read = cmd_start_i
                      && (cmd.cmdtype == DM_CMDTYPE_ACCESS_MEM)
                      && !cmd.aamwrite;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            pc_q      <= '0;
            pending_q <= 1'b0;
        end
        else
        begin
            pending_q <= is_mem_read;
            if (is_mem_read)
            begin
                pc_q <= data1_i[DM_XLEN-1:0];
            end
        end
    end

    assign pc_o = pc_q;

    // data0 captures this on the next edge
    assign mem_result_o.valid = pending_q;
    assign mem_result_o.data  = instr_i;

endmodule

/* hdl/dm_top.sv */
/*
 * debug module register slave on a classic strobe bus
 * pc_o drives the memory, which must answer combinationally on instr_i
 */
`timescale 1ns/1ns

module dm_top (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          cyc_i,
    input  logic                          stb_i,
    input  logic                          we_i,
    input  logic [dm_pkg::DM_ADDR_W-1:0]  addr_i,
    input  logic [dm_pkg::DM_DATA_W-1:0]  data_i,
    input  logic [dm_pkg::DM_XLEN-1:0]    instr_i,
    output logic                          ack_o,
    output logic [dm_pkg::DM_DATA_W-1:0]  data_o,
    output logic [dm_pkg::DM_XLEN-1:0]    pc_o
);
    import dm_pkg::*;

    dm_reg_wr_t           reg_wr;
    logic [DM_DATA_W-1:0] rd_data;
    logic [DM_DATA_W-1:0] data1;
    logic                 cmd_start;
    logic [31:0]          cmd_word;
    dm_mem_result_t       mem_result;

    // bus protocol and write strobe
    wb_dm_bus_slave u_bus (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .cyc_i     (cyc_i),
        .stb_i     (stb_i),
        .we_i      (we_i),
        .addr_i    (addr_i),
        .data_i    (data_i),
        .rd_data_i (rd_data),
        .ack_o     (ack_o),
        .data_o    (data_o),
        .reg_wr_o  (reg_wr)
    );

    // read mux uses the live bus address
    dm_register_file u_regs (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .reg_wr_i     (reg_wr),
        .addr_i       (addr_i),
        .mem_result_i (mem_result),
        .rd_data_o    (rd_data),
        .data1_o      (data1),
        .cmd_start_o  (cmd_start),
        .cmd_word_o   (cmd_word)
    );

    dm_abstract_cmd u_cmd (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cmd_start_i  (cmd_start),
        .cmd_word_i   (cmd_word),
        .data1_i      (data1),
        .instr_i      (instr_i),
        .pc_o         (pc_o),
        .mem_result_o (mem_result)
    );

endmodule

/* verif/tb_clock_gen.sv */
/*
 * free-running testbench clock, 40 ns period, starts low
 */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk_o
);
    localparam int HALF_PERIOD = 20;

    initial
    begin
        clk_o = 1'b0;
        forever
        begin
            #HALF_PERIOD clk_o = ~clk_o;
        end
    end

endmodule

/* verif/dm_assertions.sv */
/*
 * ack protocol of the bus slave, bound into every wb_dm_bus_slave
 * assumes one master that drops its request only after ack
 */
`timescale 1ns/1ns

module dm_assertions (
    input logic clk_i,
    input logic rst_i,
    input logic cyc_i,
    input logic stb_i,
    input logic ack_i
);
    logic req;
    // sticky, one per property
    logic fail_rst = 1'b0;
    logic fail_rise = 1'b0;
    logic fail_hold = 1'b0;
    logic fail_drop = 1'b0;
    logic fail_any;

    assign req = cyc_i & stb_i;
    assign fail_any = fail_rst | fail_rise | fail_hold | fail_drop;

    // reset edge clears ack
    assert property (@(posedge clk_i) rst_i |=> !ack_i)
    else
    begin
        $error("ack high after a reset edge");
        fail_rst = 1'b1;
    end

    // ack registered at edge 1, so the sampling at edge 2 sees it
    assert property (@(posedge clk_i) disable iff (rst_i) $rose(req) |=> ##1 $rose(ack_i))
    else
    begin
        $error("ack did not rise one edge after a new request");
        fail_rise = 1'b1;
    end

    assert property (@(posedge clk_i) disable iff (rst_i) (ack_i && req) |=> ack_i)
    else
    begin
        $error("ack dropped while the request was held");
        fail_hold = 1'b1;
    end

    // without a request ack is low one edge later
    assert property (@(posedge clk_i) disable iff (rst_i) !req |=> !ack_i)
    else
    begin
        $error("ack still high one edge after the request dropped");
        fail_drop = 1'b1;
    end

endmodule

bind wb_dm_bus_slave dm_assertions u_ack_asserts (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .cyc_i (cyc_i),
    .stb_i (stb_i),
    .ack_i (ack_o)
);

/* verif/tb_checker.sv */
/*
 * shadow copy of the debug registers, built from the bus writes seen
 * samples on the falling edge, master holds addr, we and data until ack
 * command field positions: cmdtype in bits 31:24, aamwrite in bit 16
 */
`timescale 1ns/1ns

module tb_checker (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        we_i,
    input  logic [31:0] addr_i,
    input  logic [63:0] data_i,
    input  logic        ack_i,
    input  logic [63:0] rd_data_i,
    input  logic [31:0] pc_i,
    input  logic [31:0] instr_i,
    input  logic        wr_strobe_i,
    output int          errors_o
);
    import dm_pkg::*;

    logic [63:0] sh_data0;
    logic [63:0] sh_data1;
    logic [63:0] sh_dmcontrol;
    logic [63:0] sh_command;
    logic [31:0] exp_pc;
    logic [31:0] exp_pc_prev;
    logic [31:0] pc_prev;
    // memory read waiting for pc_o to move
    logic [31:0] pend_pc;
    logic        pend;
    logic        ack_prev;
    logic        cyc_we;
    int          strobes;
    int          errors = 0;

    assign errors_o = errors;

    function automatic logic [63:0] ref_read(input logic [31:0] addr);
        case (addr)
            DM_ADDR_DATA0:     return sh_data0;
            DM_ADDR_DATA1:     return sh_data1;
            DM_ADDR_DMCONTROL: return sh_dmcontrol;
            DM_ADDR_COMMAND:   return sh_command;
            default:           return 64'h0;
        endcase
    endfunction

    // access-memory with aamwrite clear loads pc from data1, else pc keeps its value
    function automatic logic [31:0] ref_pc(input logic [63:0] cmd, input logic [31:0] pc);
        if ((cmd[31:24] == 8'h02) && !cmd[16])
        begin
            return sh_data1[31:0];
        end
        return pc;
    endfunction

    always @(negedge clk_i)
    begin
        if (rst_i)
        begin
            {sh_data0, sh_data1, sh_dmcontrol, sh_command} = '0;
            {exp_pc, exp_pc_prev, pc_prev, pend_pc} = '0;
            {pend, ack_prev, cyc_we} = '0;
            strobes = 0;
        end
        else
        begin
            // pc_o moved on the last edge, memory answers for it now
            if (pend)
            begin
                exp_pc = pend_pc;
                sh_data0 = {32'h0, instr_i};
                pend = 1'b0;
            end
            if (((pc_i !== pc_prev) || (exp_pc !== exp_pc_prev)) && (pc_i !== exp_pc))
            begin
                $display("mismatch pc_o: got %h, expected %h", pc_i, exp_pc);
                errors++;
            end
            pc_prev = pc_i;
            exp_pc_prev = exp_pc;
            if (!(ack_i && !we_i) && (rd_data_i !== 64'h0))
            begin
                $display("mismatch data_o outside a read ack: got %h, expected %h",
                         rd_data_i, 64'h0);
                errors++;
            end
            if (wr_strobe_i)
            begin
                strobes++;
            end
            if (ack_i && !ack_prev)
            begin
                cyc_we = we_i;
                if (!we_i && (rd_data_i !== ref_read(addr_i)))
                begin
                    $display("mismatch data_o at addr %h: got %h, expected %h",
                             addr_i, rd_data_i, ref_read(addr_i));
                    errors++;
                end
                else if (we_i)
                begin
                    case (addr_i)
                        DM_ADDR_DATA0:     sh_data0 = {32'h0, data_i[31:0]};
                        DM_ADDR_DATA1:     sh_data1 = data_i;
                        DM_ADDR_DMCONTROL: sh_dmcontrol = data_i;
                        DM_ADDR_COMMAND:
                        begin
                            sh_command = data_i;
                            pend_pc = ref_pc(data_i, exp_pc);
                            pend = (data_i[31:24] == 8'h02) && !data_i[16];
                        end
                        default:           ;
                    endcase
                end
            end
            else if (!ack_i && ack_prev)
            begin
                if (strobes != (cyc_we ? 1 : 0))
                begin
                    $display("bus cycle at addr %h issued %0d write strobes instead of %0d",
                             addr_i, strobes, cyc_we ? 1 : 0);
                    errors++;
                end
                strobes = 0;
            end
            ack_prev = ack_i;
        end
    end

endmodule

/* verif/tb_top.sv */
/*
 * testbench for dm_top, one bus cycle at a time
 * inputs change 1 ns after the rising edge, memory answers pc_o combinationally
 */
`timescale 1ns/1ns

module tb_top;
    import dm_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int ROUNDS = 8;
    localparam int HOLD_CYCLES = 5;
    localparam int NUM_TESTS = 6;
    // bus cycles per test, in test order
    localparam int TXNS = 7 * ROUNDS + 8 + 10 + 12 + 5 + 2;
    // request, ack, longest hold, release, idle gap and command wait
    localparam int TXN_CYCLES = HOLD_CYCLES + 6;
    localparam int CYCLE_LIMIT = RESET_CYCLES + TXNS * TXN_CYCLES + NUM_TESTS * 4;
    localparam logic [31:0] MAPPED [4] = '{DM_ADDR_DATA0, DM_ADDR_DATA1,
                                          DM_ADDR_DMCONTROL, DM_ADDR_COMMAND};

    logic        clk;
    logic        rst;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] addr;
    logic [63:0] wdata;
    logic [31:0] instr;
    logic        ack;
    logic [63:0] rdata;
    logic [31:0] pc;
    logic [31:0] lfsr_q;
    int          chk_errors;
    int          local_errs = 0;
    int          errs_mark = 0;
    int          failed_tests = 0;
    int          cycles = 0;

    tb_clock_gen u_clk (.clk_o(clk));

    dm_top u_dut (
        .clk_i   (clk),
        .rst_i   (rst),
        .cyc_i   (cyc),
        .stb_i   (stb),
        .we_i    (we),
        .addr_i  (addr),
        .data_i  (wdata),
        .instr_i (instr),
        .ack_o   (ack),
        .data_o  (rdata),
        .pc_o    (pc)
    );

    tb_checker u_chk (
        .clk_i       (clk),
        .rst_i       (rst),
        .we_i        (we),
        .addr_i      (addr),
        .data_i      (wdata),
        .ack_i       (ack),
        .rd_data_i   (rdata),
        .pc_i        (pc),
        .instr_i     (instr),
        .wr_strobe_i (u_dut.reg_wr.en),
        .errors_o    (chk_errors)
    );

    // memory model, address rotated left by 13 and mixed with a constant
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return {a[18:0], a[31:19]} ^ 32'h5A3C_96E1;
    endfunction

    assign instr = mem_word(pc);

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand64(output logic [63:0] v);
        v = '0;
        for (int i = 0; i < 64; i++)
        begin
            v = {v[62:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    function automatic int error_total();
        return chk_errors + local_errs + int'(u_dut.u_bus.u_ack_asserts.fail_any);
    endfunction

    // one bus cycle, request held for hold extra cycles after ack
    task automatic bus(input logic w, input logic [31:0] a, input logic [63:0] d,
                       input int hold);
        @(posedge clk);
        #1;
        {cyc, stb} = 2'b11;
        we = w;
        addr = a;
        wdata = d;
        do
        begin
            @(posedge clk);
            #1;
        end
        while (!ack);
        repeat (hold)
        begin
            @(posedge clk);
            #1;
            if (!ack)
            begin
                $display("ack dropped while the request was held at addr %h", a);
                local_errs++;
            end
        end
        {cyc, stb} = 2'b00;
        @(posedge clk);
        #1;
        if (ack)
        begin
            $display("ack still high one edge after release at addr %h", a);
            local_errs++;
        end
    endtask

    task automatic read_mapped();
        foreach (MAPPED[i])
        begin
            bus(1'b0, MAPPED[i], '0, 0);
        end
    endtask

    task automatic finish_test(input int num, input string name);
        int errs;
        repeat (3) @(posedge clk);
        #1;
        errs = error_total() - errs_mark;
        errs_mark += errs;
        if (errs == 0)
        begin
            $display("test %0d %s: ok", num, name);
        end
        else
        begin
            failed_tests++;
            $display("test %0d %s: %0d errors", num, name, errs);
        end
    endtask

    initial
    begin : watchdog
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
        $display("Regression failed");
        $finish;
    end

    initial
    begin : stimulus
        logic [63:0] v;
        logic [31:0] a;
        {rst, cyc, stb, we} = 4'b1000;
        addr = '0;
        wdata = '0;
        lfsr_q = 32'd83;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int r = 0; r < ROUNDS; r++)
        begin
            rand64(v);
            bus(1'b1, DM_ADDR_DATA1, v, 0);
            rand64(v);
            bus(1'b1, DM_ADDR_DMCONTROL, v, 0);
            rand64(v);
            // aamwrite set, so no memory read starts
            bus(1'b1, DM_ADDR_COMMAND, v | 64'h1_0000, 0);
            read_mapped();
        end
        finish_test(1, "random write and read back");

        for (int r = 0; r < 4; r++)
        begin
            rand64(v);
            bus(1'b1, DM_ADDR_DATA0, v, 0);
            bus(1'b0, DM_ADDR_DATA0, '0, 0);
        end
        finish_test(2, "data0 keeps the low word");

        for (int r = 0; r < 3; r++)
        begin
            rand64(v);
            // bit 8 set keeps it off the register map
            a = v[63:32] | 32'h100;
            bus(1'b1, a, v, 0);
            bus(1'b0, a, '0, 0);
        end
        read_mapped();
        finish_test(3, "unmapped address");

        for (int r = 0; r < 4; r++)
        begin
            rand64(v);
            bus(1'b1, DM_ADDR_DATA1, v, 0);
            // access-memory, 32-bit, read
            bus(1'b1, DM_ADDR_COMMAND, 64'h0220_0000, 0);
            repeat (2) @(posedge clk);
            bus(1'b0, DM_ADDR_DATA0, '0, 0);
        end
        finish_test(4, "memory read command");

        rand64(v);
        bus(1'b1, DM_ADDR_DATA1, v, 0);
        // register access command type
        bus(1'b1, DM_ADDR_COMMAND, 64'h0022_1000, 0);
        bus(1'b0, DM_ADDR_DATA0, '0, 0);
        // access-memory with aamwrite set
        bus(1'b1, DM_ADDR_COMMAND, 64'h0221_0000, 0);
        bus(1'b0, DM_ADDR_DATA0, '0, 0);
        finish_test(5, "other commands ignored");

        rand64(v);
        bus(1'b1, DM_ADDR_DMCONTROL, v, HOLD_CYCLES);
        bus(1'b0, DM_ADDR_DMCONTROL, '0, HOLD_CYCLES);
        finish_test(6, "held request");

        $display("%0d of %0d tests ok, %0d errors", NUM_TESTS - failed_tests, NUM_TESTS,
                 error_total());
        if ((failed_tests == 0) && (error_total() == 0))
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* files.f */
hdl/dm_pkg.sv
hdl/wb_dm_bus_slave.sv
hdl/dm_register_file.sv
hdl/dm_abstract_cmd.sv
hdl/dm_top.sv
verif/tb_clock_gen.sv
verif/dm_assertions.sv
verif/tb_checker.sv
verif/tb_top.sv

/* Makefile */
# Verilator build and run for the debug module register slave

VERILATOR   ?= verilator
TOP         ?= tb_top
FILELIST    ?= files.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
ERROR_LIMIT ?= 100
VFLAGS      ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) +verilator+error+limit+$(ERROR_LIMIT) | tee $(LOG)
	@grep -q '^Regression passed$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
